/* logic/rr_pkg.sv */
`default_nettype none

package rr_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  // host address covers both the register half and the circuit half
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  ////////////////////////////////////////////////////////////
  // trace geometry
  ////////////////////////////////////////////////////////////
  localparam int TRACE_DEPTH = 16;
  localparam int PTR_W = 4;
  // one extra bit so a full trace (16) fits in the count
  localparam int COUNT_W = PTR_W + 1;
  // write flag, address, data
  localparam int ENTRY_W = 1 + ADDR_W + DATA_W;
  localparam int ENTRY_WR_BIT = ADDR_W + DATA_W;

  typedef logic [PTR_W-1:0] trace_ptr_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [ENTRY_W-1:0] trace_entry_t;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////
  // address bit 11 high selects the unit's own registers
  localparam int CSR_SEL_BIT = 11;
  localparam addr_t CSR_MODE_OFS = 12'h800;
  localparam addr_t CSR_STATUS_OFS = 12'h804;
  localparam addr_t CSR_COUNT_OFS = 12'h808;

  // replay sequencer states
  typedef enum logic [1:0] {
    REPLAY_IDLE,
    REPLAY_SETUP,
    REPLAY_ACCESS
  } replay_state_e;

endpackage

`default_nettype wire

/* logic/rr_trace_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_trace_buffer (
  input  wire                  clk,
  input  wire                  i_wr_en,
  input  rr_pkg::trace_ptr_t   i_wr_ptr,
  input  rr_pkg::trace_entry_t i_wr_entry,
  input  rr_pkg::trace_ptr_t   i_rd_ptr,
  output rr_pkg::trace_entry_t o_rd_entry
);
  import rr_pkg::*;

  // trace storage, contents only valid below the count
  trace_entry_t mem [TRACE_DEPTH];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_ptr] <= i_wr_entry;
    end
  end

  // replay reads the entry in the same cycle it drives the bus
  assign o_rd_entry = mem[i_rd_ptr];

endmodule

`default_nettype wire

/* logic/rr_trace_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_trace_counter (
  input  wire                clk,
  input  wire                rstn,
  input  wire                i_rec_valid,
  input  wire                i_record_en,
  input  wire                i_clear,
  output rr_pkg::count_t     o_count,
  output logic               o_wr_en,
  output rr_pkg::trace_ptr_t o_wr_ptr,
  output logic               o_overflow
);
  import rr_pkg::*;

  logic rec;
  logic full;

  // strobe only counts while recording is on
  assign rec = i_rec_valid & i_record_en;
  assign full = (o_count == count_t'(TRACE_DEPTH));

  // next free slot is the current count
  assign o_wr_en = rec & ~full;
  assign o_wr_ptr = o_count[PTR_W-1:0];
  // dropped entry
  assign o_overflow = rec & full;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_count <= '0;
    end else if (i_clear) begin
      o_count <= '0;
    end else if (o_wr_en) begin
      o_count <= o_count + 1'b1;
    end
  end

  a_count_max: assert property (@(posedge clk) disable iff (!rstn)
    o_count <= count_t'(TRACE_DEPTH));

endmodule

`default_nettype wire

/* logic/rr_cfg_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_cfg_csrs (
  input  wire            clk,
  input  wire            rstn,
  input  wire            i_csr_wr,
  input  wire            i_csr_rd_en,
  input  rr_pkg::addr_t  i_csr_ofs,
  input  rr_pkg::data_t  i_csr_wdata,
  output rr_pkg::data_t  o_csr_rdata,
  input  rr_pkg::count_t i_count,
  input  wire            i_overflow,
  input  wire            i_mismatch,
  input  wire            i_replay_busy,
  output logic           o_record_en,
  output logic           o_replay_start,
  output logic           o_count_clear
);
  import rr_pkg::*;

  logic wr_mode;
  logic wr_status;
  logic overflow_q;
  logic mismatch_q;

  assign wr_mode = i_csr_wr && (i_csr_ofs == CSR_MODE_OFS);
  assign wr_status = i_csr_wr && (i_csr_ofs == CSR_STATUS_OFS);

  ////////////////////////////////////////////////////////////
  // mode and status
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_record_en <= 1'b0;
      overflow_q <= 1'b0;
      mismatch_q <= 1'b0;
    end else begin
      if (wr_mode) begin
        o_record_en <= i_csr_wdata[0];
      end
      // sticky flags, a new event wins over write-1-to-clear
      if (i_overflow) begin
        overflow_q <= 1'b1;
      end else if (wr_status && i_csr_wdata[0]) begin
        overflow_q <= 1'b0;
      end
      if (i_mismatch) begin
        mismatch_q <= 1'b1;
      end else if (wr_status && i_csr_wdata[1]) begin
        mismatch_q <= 1'b0;
      end
    end
  end

  // start pulse lives for the single access cycle of the write
  // the sequencer decides whether it is accepted
  assign o_replay_start = wr_mode & i_csr_wdata[1];
  // any write to count clears it
  assign o_count_clear = i_csr_wr && (i_csr_ofs == CSR_COUNT_OFS);

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    o_csr_rdata = '0;
    if (i_csr_rd_en) begin
      case (i_csr_ofs)
        CSR_MODE_OFS: o_csr_rdata[0] = o_record_en;
        CSR_STATUS_OFS: o_csr_rdata[2:0] = {i_replay_busy, mismatch_q, overflow_q};
        CSR_COUNT_OFS: o_csr_rdata[COUNT_W-1:0] = i_count;
        default: o_csr_rdata = '0;
      endcase
    end
  end

  // host writes are zero wait, so the start pulse never repeats
  a_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
    o_replay_start |=> !o_replay_start);

endmodule

`default_nettype wire

/* logic/rr_replay_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_replay_fsm (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  i_start,
  input  rr_pkg::count_t       i_count,
  output rr_pkg::trace_ptr_t   o_rd_ptr,
  input  rr_pkg::trace_entry_t i_rd_entry,
  output logic                 o_busy,
  output logic                 o_rp_psel,
  output logic                 o_rp_penable,
  output logic                 o_rp_pwrite,
  output rr_pkg::addr_t        o_rp_paddr,
  output rr_pkg::data_t        o_rp_pwdata,
  input  rr_pkg::data_t        i_cl_prdata,
  input  wire                  i_cl_pready,
  output logic                 o_mismatch
);
  import rr_pkg::*;

  replay_state_e state;
  trace_ptr_t ptr;
  count_t len;
  logic done;
  logic last;

  // length latched at start so a count clear mid replay cannot cut it short
  always_ff @(posedge clk) begin
    if (state == REPLAY_IDLE && i_start) begin
      len <= i_count;
    end
  end

  assign done = (state == REPLAY_ACCESS) && i_cl_pready;
  assign last = (count_t'(ptr) == len - 1'b1);

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= REPLAY_IDLE;
      ptr <= '0;
    end else begin
      case (state)
        REPLAY_IDLE: begin
          // nothing to replay for an empty trace
          if (i_start && i_count != '0) begin
            ptr <= '0;
            state <= REPLAY_SETUP;
          end
        end
        REPLAY_SETUP: state <= REPLAY_ACCESS;
        REPLAY_ACCESS: begin
          if (i_cl_pready) begin
            if (last) begin
              state <= REPLAY_IDLE;
            end else begin
              ptr <= ptr + 1'b1;
              state <= REPLAY_SETUP;
            end
          end
        end
        default: state <= REPLAY_IDLE;
      endcase
    end
  end

  assign o_busy = (state != REPLAY_IDLE);
  assign o_rd_ptr = ptr;

  // apb master fields straight from the current entry
  assign o_rp_psel = o_busy;
  assign o_rp_penable = (state == REPLAY_ACCESS);
  assign o_rp_pwrite = i_rd_entry[ENTRY_WR_BIT];
  assign o_rp_paddr = i_rd_entry[DATA_W +: ADDR_W];
  assign o_rp_pwdata = i_rd_entry[DATA_W-1:0];

  // validation of replayed reads against the recorded data
  assign o_mismatch = done & ~o_rp_pwrite & (i_cl_prdata != i_rd_entry[DATA_W-1:0]);

  // trace fields hold still from setup through the whole access phase
  a_access_stable: assert property (@(posedge clk) disable iff (!rstn)
    o_rp_penable |-> $stable(o_rp_paddr) && $stable(o_rp_pwrite) && $stable(o_rp_pwdata));

endmodule

`default_nettype wire

/* logic/rr_bar_router.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_bar_router (
  input  wire                  clk,
  input  wire                  rstn,
  // host apb slave
  input  wire                  i_psel,
  input  wire                  i_penable,
  input  wire                  i_pwrite,
  input  rr_pkg::addr_t        i_paddr,
  input  rr_pkg::data_t        i_pwdata,
  output rr_pkg::data_t        o_prdata,
  output logic                 o_pready,
  // register space
  output logic                 o_csr_wr,
  output logic                 o_csr_rd_en,
  output rr_pkg::addr_t        o_csr_ofs,
  output rr_pkg::data_t        o_csr_wdata,
  input  rr_pkg::data_t        i_csr_rdata,
  // replay master
  input  wire                  i_replay_busy,
  input  wire                  i_rp_psel,
  input  wire                  i_rp_penable,
  input  wire                  i_rp_pwrite,
  input  rr_pkg::addr_t        i_rp_paddr,
  input  rr_pkg::data_t        i_rp_pwdata,
  // record strobe
  output logic                 o_rec_valid,
  output rr_pkg::trace_entry_t o_rec_entry,
  // user circuit apb master
  output logic                 o_cl_psel,
  output logic                 o_cl_penable,
  output logic                 o_cl_pwrite,
  output rr_pkg::addr_t        o_cl_paddr,
  output rr_pkg::data_t        o_cl_pwdata,
  input  rr_pkg::data_t        i_cl_prdata,
  input  wire                  i_cl_pready
);
  import rr_pkg::*;

  logic csr_sel;
  logic host_cl;
  logic host_wait;
  logic host_done;

  // single decode of the register half
  assign csr_sel = i_paddr[CSR_SEL_BIT];
  assign host_cl = i_psel & ~csr_sel;

  ////////////////////////////////////////////////////////////
  // register space, zero wait
  ////////////////////////////////////////////////////////////
  assign o_csr_wr = i_psel & i_penable & csr_sel & i_pwrite;
  assign o_csr_rd_en = i_psel & i_penable & csr_sel & ~i_pwrite;
  assign o_csr_ofs = i_paddr;
  assign o_csr_wdata = i_pwdata;

  ////////////////////////////////////////////////////////////
  // circuit port mux
  ////////////////////////////////////////////////////////////
  // host held off by replay last cycle
  // the circuit then gets a fresh setup cycle before access
  always_ff @(posedge clk) begin
    if (!rstn) begin
      host_wait <= 1'b0;
    end else begin
      host_wait <= host_cl & i_replay_busy;
    end
  end

  // replay owns the port while busy
  assign o_cl_psel = i_replay_busy ? i_rp_psel : host_cl;
  assign o_cl_penable = i_replay_busy ? i_rp_penable : host_cl & i_penable & ~host_wait;
  assign o_cl_pwrite = i_replay_busy ? i_rp_pwrite : i_pwrite;
  assign o_cl_paddr = i_replay_busy ? i_rp_paddr : i_paddr;
  assign o_cl_pwdata = i_replay_busy ? i_rp_pwdata : i_pwdata;

  // host circuit transfer finishes only once it really owns the port
  assign host_done = host_cl & i_penable & ~i_replay_busy & ~host_wait & i_cl_pready;

  assign o_pready = csr_sel ? (i_psel & i_penable) : host_done;
  assign o_prdata = csr_sel ? i_csr_rdata : i_cl_prdata;

  // record strobe, read entries take the circuit's data
  assign o_rec_valid = host_done;
  assign o_rec_entry = {i_pwrite, i_paddr, i_pwrite ? i_pwdata : i_cl_prdata};

  // a stalled host transfer must not be traced in the middle of a replay
  a_no_rec_busy: assert property (@(posedge clk) disable iff (!rstn)
    o_rec_valid |-> !i_replay_busy && !$past(i_replay_busy));

endmodule

`default_nettype wire

/* logic/rr_apb_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_apb_wrapper (
  input  wire            clk,
  input  wire            rstn,
  // host side
  input  wire            i_psel,
  input  wire            i_penable,
  input  wire            i_pwrite,
  input  rr_pkg::addr_t  i_paddr,
  input  rr_pkg::data_t  i_pwdata,
  output rr_pkg::data_t  o_prdata,
  output logic           o_pready,
  // user circuit side
  output logic           o_cl_psel,
  output logic           o_cl_penable,
  output logic           o_cl_pwrite,
  output rr_pkg::addr_t  o_cl_paddr,
  output rr_pkg::data_t  o_cl_pwdata,
  input  rr_pkg::data_t  i_cl_prdata,
  input  wire            i_cl_pready
);
  import rr_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////
  logic csr_wr;
  logic csr_rd_en;
  addr_t csr_ofs;
  data_t csr_wdata;
  data_t csr_rdata;
  logic record_en;
  logic replay_start;
  logic count_clear;
  count_t count;
  logic overflow;
  logic mismatch;
  logic rec_valid;
  trace_entry_t rec_entry;
  logic wr_en;
  trace_ptr_t wr_ptr;
  trace_ptr_t rd_ptr;
  trace_entry_t rd_entry;
  // replay master
  logic busy;
  logic rp_psel;
  logic rp_penable;
  logic rp_pwrite;
  addr_t rp_paddr;
  data_t rp_pwdata;

  rr_bar_router u_router (
    .clk(clk), .rstn(rstn),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready),
    .o_csr_wr(csr_wr), .o_csr_rd_en(csr_rd_en),
    .o_csr_ofs(csr_ofs), .o_csr_wdata(csr_wdata), .i_csr_rdata(csr_rdata),
    .i_replay_busy(busy),
    .i_rp_psel(rp_psel), .i_rp_penable(rp_penable), .i_rp_pwrite(rp_pwrite),
    .i_rp_paddr(rp_paddr), .i_rp_pwdata(rp_pwdata),
    .o_rec_valid(rec_valid), .o_rec_entry(rec_entry),
    .o_cl_psel(o_cl_psel), .o_cl_penable(o_cl_penable), .o_cl_pwrite(o_cl_pwrite),
    .o_cl_paddr(o_cl_paddr), .o_cl_pwdata(o_cl_pwdata),
    .i_cl_prdata(i_cl_prdata), .i_cl_pready(i_cl_pready)
  );

  rr_cfg_csrs u_csrs (
    .clk(clk), .rstn(rstn),
    .i_csr_wr(csr_wr), .i_csr_rd_en(csr_rd_en),
    .i_csr_ofs(csr_ofs), .i_csr_wdata(csr_wdata), .o_csr_rdata(csr_rdata),
    .i_count(count), .i_overflow(overflow), .i_mismatch(mismatch),
    .i_replay_busy(busy),
    .o_record_en(record_en), .o_replay_start(replay_start),
    .o_count_clear(count_clear)
  );

  rr_trace_counter u_counter (
    .clk(clk), .rstn(rstn),
    .i_rec_valid(rec_valid), .i_record_en(record_en), .i_clear(count_clear),
    .o_count(count), .o_wr_en(wr_en), .o_wr_ptr(wr_ptr), .o_overflow(overflow)
  );

  rr_trace_buffer u_buffer (
    .clk(clk),
    .i_wr_en(wr_en), .i_wr_ptr(wr_ptr), .i_wr_entry(rec_entry),
    .i_rd_ptr(rd_ptr), .o_rd_entry(rd_entry)
  );

  rr_replay_fsm u_replay (
    .clk(clk), .rstn(rstn),
    .i_start(replay_start), .i_count(count),
    .o_rd_ptr(rd_ptr), .i_rd_entry(rd_entry), .o_busy(busy),
    .o_rp_psel(rp_psel), .o_rp_penable(rp_penable), .o_rp_pwrite(rp_pwrite),
    .o_rp_paddr(rp_paddr), .o_rp_pwdata(rp_pwdata),
    .i_cl_prdata(i_cl_prdata), .i_cl_pready(i_cl_pready),
    .o_mismatch(mismatch)
  );

endmodule

`default_nettype wire

/* tests/tb_rr_apb_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rr_apb_wrapper;
  import rr_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 16;
  localparam int WATCHDOG_CYCLES = 20000;
  // entries recorded by the replay test, 4 writes and 5 reads
  localparam int REPLAY_LEN = 9;
  localparam int POLL_MAX = 100;

  logic clk;
  logic rstn;
  logic psel;
  logic penable;
  logic pwrite;
  addr_t paddr;
  data_t pwdata;
  data_t prdata;
  logic pready;
  logic cl_psel;
  logic cl_penable;
  logic cl_pwrite;
  addr_t cl_paddr;
  data_t cl_pwdata;
  data_t cl_prdata;
  logic cl_pready;

  // user circuit model state
  data_t model_mem [16];
  int seed;
  int pick;
  int wait_left;
  int checks;
  int errors;

  rr_apb_wrapper DUT (
    .clk(clk), .rstn(rstn),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
    .o_cl_psel(cl_psel), .o_cl_penable(cl_penable), .o_cl_pwrite(cl_pwrite),
    .o_cl_paddr(cl_paddr), .o_cl_pwdata(cl_pwdata),
    .i_cl_prdata(cl_prdata), .i_cl_pready(cl_pready)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////
  // user circuit apb slave with 0 to 2 wait cycles per transfer
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    // word index from address bits 5:2
    if (cl_psel) begin
      cl_prdata <= model_mem[cl_paddr[5:2]];
    end
    if (cl_psel && cl_penable && cl_pready) begin
      if (cl_pwrite) begin
        model_mem[cl_paddr[5:2]] <= cl_pwdata;
      end
      cl_pready <= 1'b0;
    end else if (cl_psel && !cl_penable) begin
      // setup cycle picks the wait count
      pick = $unsigned($random(seed)) % 3;
      wait_left <= pick;
      cl_pready <= (pick == 0);
    end else if (cl_psel && cl_penable) begin
      if (wait_left <= 1) begin
        cl_pready <= 1'b1;
      end
      wait_left <= wait_left - 1;
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic data_t word_pattern(input logic [3:0] idx);
    return {8'hA5, idx, ~idx, idx * 8'd17, {4'h0, idx} ^ 8'h3C};
  endfunction

  function automatic addr_t cl_addr(input logic [3:0] idx);
    return {6'b0, idx, 2'b00};
  endfunction

  // one apb transfer that returns at the falling edge after completion
  task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                          output data_t rdata);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // ready seen mid cycle completes at the next rising edge
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    @(negedge clk);
  endtask

  task automatic host_write(input addr_t addr, input data_t wdata);
    data_t unused;
    apb_xfer(1'b1, addr, wdata, unused);
  endtask

  task automatic host_read(input addr_t addr, output data_t rdata);
    apb_xfer(1'b0, addr, '0, rdata);
  endtask

  task automatic check_val(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail @%0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  // polls status until the busy bit drops
  task automatic wait_replay_idle();
    data_t rd;
    int polls;
    polls = 0;
    rd = 32'h4;
    while (rd[2] && polls < POLL_MAX) begin
      host_read(CSR_STATUS_OFS, rd);
      polls++;
    end
    checks++;
    assert (!rd[2]) else begin
      errors++;
      $display("replay still busy after %0d status reads", POLL_MAX);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_and_clear();
    data_t rd;
    int e0;
    e0 = errors;
    // circuit select, circuit enable and host ready all idle
    check_val("idle port after reset", data_t'({cl_psel, cl_penable, pready}), '0);
    host_read(CSR_MODE_OFS, rd);
    check_val("mode after reset", rd, '0);
    host_read(CSR_STATUS_OFS, rd);
    check_val("status after reset", rd, '0);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count after reset", rd, '0);
    host_write(CSR_MODE_OFS, 32'h1);
    host_write(cl_addr(4'd5), 32'h1234_5678);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count after one record", rd, 32'd1);
    // any value written to count clears it
    host_write(CSR_COUNT_OFS, 32'hFFFF_FFFF);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count after clear", rd, '0);
    host_write(CSR_MODE_OFS, 32'h0);
    report_test("reset_clear", e0);
  endtask

  task automatic pass_through_access();
    data_t rd;
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      host_write(cl_addr(4'(i)), word_pattern(4'(i)) ^ 32'h0F0F_0F0F);
      check_val("model word after write", model_mem[i], word_pattern(4'(i)) ^ 32'h0F0F_0F0F);
    end
    for (int i = 8; i < 16; i++) begin
      model_mem[i] = word_pattern(4'(i));
    end
    for (int i = 0; i < 16; i++) begin
      host_read(cl_addr(4'(i)), rd);
      check_val("pass-through read", rd, model_mem[i]);
    end
    report_test("pass_through", e0);
  endtask

  task automatic record_gating();
    data_t rd;
    int e0;
    e0 = errors;
    host_write(CSR_COUNT_OFS, 32'h0);
    host_write(CSR_MODE_OFS, 32'h1);
    host_write(cl_addr(4'd1), 32'hAAAA_0001);
    host_read(CSR_STATUS_OFS, rd);
    host_read(cl_addr(4'd1), rd);
    host_write(cl_addr(4'd2), 32'hAAAA_0002);
    host_read(CSR_MODE_OFS, rd);
    host_read(cl_addr(4'd9), rd);
    host_write(cl_addr(4'd3), 32'hAAAA_0003);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count while recording", rd, 32'd5);
    // count must hold with recording off
    host_write(CSR_MODE_OFS, 32'h0);
    host_write(cl_addr(4'd4), 32'hBBBB_0004);
    host_read(cl_addr(4'd4), rd);
    host_write(cl_addr(4'd6), 32'hBBBB_0006);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count with recording off", rd, 32'd5);
    report_test("record_gating", e0);
  endtask

  task automatic overflow_flag();
    data_t rd;
    int e0;
    e0 = errors;
    host_write(CSR_COUNT_OFS, 32'h0);
    host_write(CSR_STATUS_OFS, 32'h3);
    host_write(CSR_MODE_OFS, 32'h1);
    for (int i = 0; i < 20; i++) begin
      host_write(cl_addr(4'(i % 16)), 32'hC000_0000 + i);
    end
    host_write(CSR_MODE_OFS, 32'h0);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count when full", rd, 32'd16);
    host_read(CSR_STATUS_OFS, rd);
    check_val("overflow flag", data_t'(rd[0]), data_t'(1'b1));
    host_write(CSR_STATUS_OFS, 32'h1);
    host_read(CSR_STATUS_OFS, rd);
    check_val("overflow after clear", data_t'(rd[0]), data_t'(1'b0));
    report_test("overflow", e0);
  endtask

  task automatic replay_and_validate();
    data_t rd;
    int e0;
    e0 = errors;
    host_write(CSR_COUNT_OFS, 32'h0);
    host_write(CSR_STATUS_OFS, 32'h3);
    // word 4 is read but never written so it is recorded as zero
    model_mem[4] = '0;
    host_write(CSR_MODE_OFS, 32'h1);
    for (int i = 0; i < 4; i++) begin
      host_write(cl_addr(4'(i)), word_pattern(4'(i)) ^ 32'hFFFF_0000);
    end
    for (int i = 0; i < 5; i++) begin
      host_read(cl_addr(4'(i)), rd);
      check_val("recorded read", rd, (i < 4) ? word_pattern(4'(i)) ^ 32'hFFFF_0000 : '0);
    end
    host_write(CSR_MODE_OFS, 32'h0);
    host_read(CSR_COUNT_OFS, rd);
    check_val("count before replay", rd, 32'(REPLAY_LEN));
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = '0;
    end
    host_write(CSR_MODE_OFS, 32'h2);
    host_read(CSR_STATUS_OFS, rd);
    check_val("busy during replay", data_t'(rd[2]), data_t'(1'b1));
    wait_replay_idle();
    for (int i = 0; i < 4; i++) begin
      check_val("replayed word", model_mem[i], word_pattern(4'(i)) ^ 32'hFFFF_0000);
    end
    host_read(CSR_STATUS_OFS, rd);
    check_val("mismatch after clean replay", data_t'(rd[1]), data_t'(1'b0));
    // the replay never writes word 4 so its read must now disagree
    model_mem[4] = 32'h0000_BEEF;
    host_write(CSR_MODE_OFS, 32'h2);
    wait_replay_idle();
    host_read(CSR_STATUS_OFS, rd);
    check_val("mismatch after changed word", data_t'(rd[1]), data_t'(1'b1));
    host_write(CSR_STATUS_OFS, 32'h2);
    host_read(CSR_STATUS_OFS, rd);
    check_val("mismatch after clear", data_t'(rd[1]), data_t'(1'b0));
    report_test("replay", e0);
  endtask

  task automatic host_stall_during_replay();
    data_t rd;
    time t0;
    int cycles;
    int e0;
    e0 = errors;
    model_mem[4] = '0;
    host_write(CSR_MODE_OFS, 32'h2);
    t0 = $time;
    // word 3 is also written by the replay
    host_write(cl_addr(4'd3), 32'hC0FF_EE42);
    cycles = int'(($time - t0) / (2 * CLK_HALF));
    checks++;
    // every replayed entry takes a setup and at least one access cycle
    assert (cycles >= 2 * REPLAY_LEN) else begin
      errors++;
      $display("host write during replay finished after only %0d cycles", cycles);
    end
    host_read(CSR_STATUS_OFS, rd);
    check_val("busy after stalled write", data_t'(rd[2]), data_t'(1'b0));
    check_val("model word after stalled write", model_mem[3], 32'hC0FF_EE42);
    check_val("mismatch after stall replay", data_t'(rd[1]), data_t'(1'b0));
    report_test("host_stall", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cl_prdata = '0;
    cl_pready = 1'b0;
    seed = 74774;
    wait_left = 0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = word_pattern(4'(i));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    reset_and_clear();
    pass_through_access();
    record_gating();
    overflow_flag();
    replay_and_validate();
    host_stall_during_replay();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rr_apb.f */
logic/rr_pkg.sv
logic/rr_trace_buffer.sv
logic/rr_trace_counter.sv
logic/rr_cfg_csrs.sv
logic/rr_replay_fsm.sv
logic/rr_bar_router.sv
logic/rr_apb_wrapper.sv
tests/tb_rr_apb_wrapper.sv

/* Bender.yml */
package:
  name: rr_apb

sources:
  - logic/rr_pkg.sv
  - logic/rr_trace_buffer.sv
  - logic/rr_trace_counter.sv
  - logic/rr_cfg_csrs.sv
  - logic/rr_replay_fsm.sv
  - logic/rr_bar_router.sv
  - logic/rr_apb_wrapper.sv
  - target: test
    files:
      - tests/tb_rr_apb_wrapper.sv
